// File: Bender.yml
package:
  name: csi_rx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/csiRxPkg.sv
      - design/csiLaneMerge.sv
      - design/csiWordFifo.sv
      - design/csiHeaderParser.sv
      - design/csiPixelHandshake.sv
      - design/csiRxTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/csiRxTb.sv

// File: design/csiHeaderParser.sv
// CSI-2 packet header parser
`timescale 1ns/1ps
`include "csiRx_defs.svh"

module csiHeaderParser
	import csiRxPkg::*;
(
	input  logic        iSCLK,
	input  logic        qnHsRst,
	// FIFO read side
	output logic        rdEn,
	input  logic [16:0] rdData,
	input  logic        rdValid,
	input  logic        empty,
	// Payload word out
	output logic        pixValid,
	input  logic        pixReady,
	output logic [15:0] pixData,
	output logic        pixLast,
	// Packet header fields
	output csiDataType  dataType,
	output logic [1:0]  vc,
	output logic [15:0] wordCnt
);

hsState rHsSt;

logic [`CSI_LINE_CNT_W-1:0] rPayCnt;	// Words forwarded so far
logic [`CSI_LINE_CNT_W-1:0] rLastIdx;	// Index of final word
logic [16:0]                qWcRound;
logic [15:0]                qWords;
logic                       qSyncWord;
logic                       qPayWord;
logic                       qPayEnd;
logic                       qLongPkt;

// ----------------------------------------
// Decode of the current FIFO word
// ----------------------------------------
assign qSyncWord = rdValid & rdData[16];			// Line start flag
assign qPayWord  = rdValid & (rHsSt == hsPayload);
assign qPayEnd   = qPayWord & (rPayCnt == rLastIdx);

// Two bytes per word so round the byte count up
assign qWcRound = {1'b0, wordCnt} + 17'd1;
assign qWords   = qWcRound[16:1];

// Zero length long packets have nothing to forward
assign qLongPkt = (dataType > `CSI_LONG_DT_MIN) && (wordCnt != 16'd0);

// One read in flight and only toward a free output stage
assign rdEn = ~empty & ~rdValid & pixReady;

// ----------------------------------------
// Packet FSM
// ----------------------------------------
always_ff @(posedge iSCLK, negedge qnHsRst)
begin
	if (!qnHsRst)
		rHsSt <= hsIdle;
	else
	begin
		case (rHsSt)
			hsIdle:
				if (qSyncWord)
					rHsSt <= hsHdrLo;	// Drop everything before sync
			hsHdrLo:
				if (rdValid)
					rHsSt <= hsHdrHi;
			hsHdrHi:
				if (rdValid)
					rHsSt <= hsDtCheck;
			hsDtCheck:
				rHsSt <= qLongPkt ? hsPayload : hsIdle;	// Short packets dropped
			hsPayload:
				if (qPayEnd)
					rHsSt <= hsIdle;
			default:
				rHsSt <= hsIdle;
		endcase
	end
end

// ----------------------------------------
// Header fields and payload data
// ----------------------------------------
always_ff @(posedge iSCLK)
begin
	if ((rHsSt == hsHdrLo) && rdValid)
	begin
		vc           <= rdData[7:6];
		dataType     <= csiDataType'(rdData[5:0]);
		wordCnt[7:0] <= rdData[15:8];	// Word count LSB
	end
	if ((rHsSt == hsHdrHi) && rdValid)
		wordCnt[15:8] <= rdData[7:0];	// ECC in upper byte not checked
	if (rHsSt == hsDtCheck)
		rLastIdx <= qWords[`CSI_LINE_CNT_W-1:0] - 1'b1;
	if (qPayWord)
	begin
		pixData <= rdData[15:0];
		pixLast <= (rPayCnt == rLastIdx);	// End of line marker
	end
end

// ----------------------------------------
// Payload counter and output valid
// ----------------------------------------
always_ff @(posedge iSCLK, negedge qnHsRst)
begin
	if (!qnHsRst)
	begin
		rPayCnt  <= '0;
		pixValid <= 1'b0;
	end
	else
	begin
		if (rHsSt == hsDtCheck)
			rPayCnt <= '0;			// Restart per packet
		else if (qPayWord)
			rPayCnt <= rPayCnt + 1'b1;

		if (qPayWord)
			pixValid <= 1'b1;
		else if (pixReady)
			pixValid <= 1'b0;		// Taken by output stage
	end
end

endmodule

// File: design/csiLaneMerge.sv
// Two-lane byte merge
`timescale 1ns/1ps

module csiLaneMerge
(
	input  logic        iSCLK,
	input  logic        qnHsRst,
	// PHY byte lanes, already aligned
	input  logic [7:0]  iHsData0,
	input  logic [7:0]  iHsData1,
	input  logic        iHsValid,	// Lane0 HS valid
	input  logic        iHsSync,	// Lane0 sync observed
	// FIFO write side
	input  logic        full,
	output logic [16:0] wrData,
	output logic        wrEn,
	// Status
	output logic        oOverflow
);

// ----------------------------------------
// PHY input registers
// ----------------------------------------
logic [7:0] rLane0;
logic [7:0] rLane1;
logic       rValid;		// Word present this cycle
logic       rSync;		// Line start marker
logic       rOverflow;

// Lane bytes carry no control meaning
always_ff @(posedge iSCLK)
begin
	rLane0 <= iHsData0;
	rLane1 <= iHsData1;
end

always_ff @(posedge iSCLK, negedge qnHsRst)
begin
	if (!qnHsRst)
	begin
		rValid <= 1'b0;
		rSync  <= 1'b0;
	end
	else
	begin
		rValid <= iHsValid | iHsSync;	// Sync word is also written
		rSync  <= iHsSync;
	end
end

// ----------------------------------------
// Overflow tracking
// ----------------------------------------
// PHY cannot stall so a write into a full FIFO loses the word
always_ff @(posedge iSCLK, negedge qnHsRst)
begin
	if (!qnHsRst)
		rOverflow <= 1'b0;
	else if (rValid && full)
		rOverflow <= 1'b1;	// Sticky until reset
end

// FIFO word layout is sync flag then lane1 then lane0
assign wrData    = {rSync, rLane1, rLane0};
assign wrEn      = rValid;	// FIFO gates with full
assign oOverflow = rOverflow;

endmodule

// File: design/csiPixelHandshake.sv
// Four-phase pixel output stage
`timescale 1ns/1ps

module csiPixelHandshake
	import csiRxPkg::*;
(
	input  logic        iSCLK,
	input  logic        qnHsRst,
	// From parser
	input  logic        pixValid,
	output logic        pixReady,
	input  logic [15:0] pixData,
	input  logic        pixLast,
	input  csiDataType  dataType,
	input  logic [1:0]  vc,
	input  logic [15:0] wordCnt,
	// Sink port
	output logic [15:0] oPixel,
	output logic        oLast,
	output logic [5:0]  oDataType,
	output logic [1:0]  oVc,
	output logic [15:0] oWordCnt,
	output logic        oReq,
	input  logic        iAck
);

outState rOutSt;

// ----------------------------------------
// Holding register
// ----------------------------------------
csiDataType rDataType;

// Loaded only in idle so the sink sees stable data during oReq
always_ff @(posedge iSCLK)
begin
	if (pixValid && pixReady)
	begin
		oPixel    <= pixData;
		oLast     <= pixLast;
		rDataType <= dataType;
		oVc       <= vc;
		oWordCnt  <= wordCnt;
	end
end

assign oDataType = rDataType;

// ----------------------------------------
// Req/ack controller
// ----------------------------------------
always_ff @(posedge iSCLK, negedge qnHsRst)
begin
	if (!qnHsRst)
		rOutSt <= outIdle;
	else
	begin
		case (rOutSt)
			outIdle:
				if (pixValid)
					rOutSt <= outReq;		// Word latched
			outReq:
				if (iAck)
					rOutSt <= outWaitAckLow;	// Drop req next cycle
			outWaitAckLow:
				if (!iAck)
					rOutSt <= outIdle;		// Cycle complete
			default:
				rOutSt <= outIdle;
		endcase
	end
end

assign pixReady = (rOutSt == outIdle);
assign oReq     = (rOutSt == outReq);

endmodule

// File: design/csiRxPkg.sv
// CSI-2 receiver types
package csiRxPkg;

	// ----------------------------------------
	// Header parser FSM
	// ----------------------------------------
	typedef enum logic [2:0]
	{
		hsIdle    = 3'd0,	// Hunt for sync word
		hsHdrLo   = 3'd1,	// Data ID and word count LSB
		hsHdrHi   = 3'd2,	// Word count MSB and ECC
		hsDtCheck = 3'd3,	// Long or short packet
		hsPayload = 3'd4	// Forward payload words
	} hsState;

	// ----------------------------------------
	// Sink handshake FSM
	// ----------------------------------------
	typedef enum logic [1:0]
	{
		outIdle       = 2'd0,	// Holding register free
		outReq        = 2'd1,	// Request raised to sink
		outWaitAckLow = 2'd2	// Wait for ack release
	} outState;

	// ----------------------------------------
	// CSI-2 data identifiers
	// ----------------------------------------
	typedef enum logic [5:0]
	{
		dtFrameStart = 6'h00,	// Short packet
		dtFrameEnd   = 6'h01,	// Short packet
		dtLineStart  = 6'h02,	// Short packet
		dtYuv422     = 6'h1E,	// YUV422 8 bit
		dtRgb565     = 6'h22,	// RGB565
		dtRaw8       = 6'h2A	// RAW8
	} csiDataType;

endpackage

// File: design/csiRxTop.sv
// CSI-2 two-lane receiver top
`timescale 1ns/1ps

module csiRxTop
	import csiRxPkg::*;
(
	input  logic        iSCLK,
	input  logic        qnHsRst,
	// D-PHY HS byte lanes
	input  logic [7:0]  iHsData0,
	input  logic [7:0]  iHsData1,
	input  logic        iHsValid,
	input  logic        iHsSync,
	// Pixel sink
	output logic [15:0] oPixel,
	output logic        oLast,
	output logic [5:0]  oDataType,
	output logic [1:0]  oVc,
	output logic [15:0] oWordCnt,
	output logic        oReq,
	input  logic        iAck,
	// Status
	output logic        oOverflow
);

// ----------------------------------------
// Stage interconnect
// ----------------------------------------
logic [16:0] wWrData;
logic        wWrEn;
logic        wFull;
logic        wRdEn;
logic [16:0] wRdData;
logic        wRdValid;
logic        wEmpty;
logic        wPixValid;
logic        wPixReady;
logic [15:0] wPixData;
logic        wPixLast;
csiDataType  wDataType;
logic [1:0]  wVc;
logic [15:0] wWordCnt;

csiLaneMerge uLaneMerge
(
	.iSCLK(iSCLK),			.qnHsRst(qnHsRst),
	.iHsData0(iHsData0),	.iHsData1(iHsData1),
	.iHsValid(iHsValid),	.iHsSync(iHsSync),
	.full(wFull),			.wrData(wWrData),
	.wrEn(wWrEn),			.oOverflow(oOverflow)
);

csiWordFifo uWordFifo
(
	.iSCLK(iSCLK),			.qnHsRst(qnHsRst),
	.wrData(wWrData),		.wrEn(wWrEn),		.full(wFull),
	.rdEn(wRdEn),			.rdData(wRdData),
	.rdValid(wRdValid),		.empty(wEmpty)
);

csiHeaderParser uHeaderParser
(
	.iSCLK(iSCLK),			.qnHsRst(qnHsRst),
	.rdEn(wRdEn),			.rdData(wRdData),
	.rdValid(wRdValid),		.empty(wEmpty),
	.pixValid(wPixValid),	.pixReady(wPixReady),
	.pixData(wPixData),		.pixLast(wPixLast),
	.dataType(wDataType),	.vc(wVc),			.wordCnt(wWordCnt)
);

csiPixelHandshake uPixelHandshake
(
	.iSCLK(iSCLK),			.qnHsRst(qnHsRst),
	.pixValid(wPixValid),	.pixReady(wPixReady),
	.pixData(wPixData),		.pixLast(wPixLast),
	.dataType(wDataType),	.vc(wVc),			.wordCnt(wWordCnt),
	.oPixel(oPixel),		.oLast(oLast),
	.oDataType(oDataType),	.oVc(oVc),			.oWordCnt(oWordCnt),
	.oReq(oReq),			.iAck(iAck)
);

endmodule

// File: design/csiWordFifo.sv
// Synchronous word FIFO
`timescale 1ns/1ps
`include "csiRx_defs.svh"

module csiWordFifo
#(
	parameter int pDepth = `CSI_FIFO_DEPTH	// Power of two
)
(
	input  logic        iSCLK,
	input  logic        qnHsRst,
	// Write side
	input  logic [16:0] wrData,
	input  logic        wrEn,
	output logic        full,
	// Read side
	input  logic        rdEn,
	output logic [16:0] rdData,
	output logic        rdValid,
	output logic        empty
);

localparam int lpAw = $clog2(pDepth);

// ----------------------------------------
// Storage and pointers
// ----------------------------------------
logic [16:0]   rMem [pDepth];
logic [lpAw:0] rWrPtr;		// Extra MSB marks wrap
logic [lpAw:0] rRdPtr;
logic          qWrAcc;
logic          qRdAcc;

assign qWrAcc = wrEn & ~full;	// Write dropped when full
assign qRdAcc = rdEn & ~empty;	// Read ignored when empty

// Same address with different wrap bit means full
assign full  = (rWrPtr[lpAw] != rRdPtr[lpAw]) &&
               (rWrPtr[lpAw-1:0] == rRdPtr[lpAw-1:0]);
assign empty = (rWrPtr == rRdPtr);

always_ff @(posedge iSCLK)
begin
	if (qWrAcc)
		rMem[rWrPtr[lpAw-1:0]] <= wrData;
	if (qRdAcc)
		rdData <= rMem[rRdPtr[lpAw-1:0]];	// Registered read port
end

// ----------------------------------------
// Pointer and valid control
// ----------------------------------------
always_ff @(posedge iSCLK, negedge qnHsRst)
begin
	if (!qnHsRst)
	begin
		rWrPtr  <= '0;
		rRdPtr  <= '0;
		rdValid <= 1'b0;
	end
	else
	begin
		if (qWrAcc)
			rWrPtr <= rWrPtr + 1'b1;
		if (qRdAcc)
			rRdPtr <= rRdPtr + 1'b1;
		rdValid <= qRdAcc;	// Data ready one cycle later
	end
end

endmodule

// File: include/csiRx_defs.svh
// CSI-2 receiver shared defines
`ifndef CSI_RX_DEFS_SVH
`define CSI_RX_DEFS_SVH

// ----------------------------------------
// Word FIFO sizing
// ----------------------------------------

// Address bits of the word FIFO
`define CSI_FIFO_AW 4

// Entries in the word FIFO
`define CSI_FIFO_DEPTH (1 << `CSI_FIFO_AW)

// ----------------------------------------
// Packet decode
// ----------------------------------------

// Data types above this value carry a payload
`define CSI_LONG_DT_MIN 6'h13

// Payload word counter width for lines of up to 8K words
`define CSI_LINE_CNT_W 13

`endif

// File: tb.f
+incdir+include
design/csiRxPkg.sv
design/csiLaneMerge.sv
design/csiWordFifo.sv
design/csiHeaderParser.sv
design/csiPixelHandshake.sv
design/csiRxTop.sv
testbench/csiRxTb.sv

// File: testbench/csiRxTb.sv
// CSI-2 receiver testbench
`timescale 1ns/1ps
`include "csiRx_defs.svh"

module csiRxTb
	import csiRxPkg::*;
();

localparam int nPkt   = 7;	// Rows in packet table
localparam int nTests = 5;

// ----------------------------------------
// DUT signals
// ----------------------------------------
logic        iSCLK;
logic        qnHsRst;
logic [7:0]  iHsData0;
logic [7:0]  iHsData1;
logic        iHsValid;
logic        iHsSync;
logic [15:0] oPixel;
logic        oLast;
logic [5:0]  oDataType;
logic [1:0]  oVc;
logic [15:0] oWordCnt;
logic        oReq;
logic        iAck;
logic        oOverflow;

// ----------------------------------------
// Packet table and scoreboard
// ----------------------------------------
int          tabTest  [nPkt];	// Rows of one test go back to back
csiDataType  tabDt    [nPkt];
logic [1:0]  tabVc    [nPkt];
logic [15:0] tabWc    [nPkt];	// Header byte count
int          tabDelay [nPkt];	// Max ack delay in cycles
bit          tabOvf   [nPkt];	// Overflow expected
string       tName    [1:nTests];

logic [15:0] expPix [$];		// Payload words in send order
logic [24:0] expTag [$];		// Last, data type, vc, word count
int          errCount   = 0;
int          rxCount    = 0;
int          maxDelay   = 0;
bit          ovfTest    = 1'b0;	// Sink only acks, no compare
bit          sinkBusy   = 1'b0;
bit          tableReady = 1'b0;
int unsigned seed;

csiRxTop u_dut
(
	.iSCLK(iSCLK),			.qnHsRst(qnHsRst),
	.iHsData0(iHsData0),	.iHsData1(iHsData1),
	.iHsValid(iHsValid),	.iHsSync(iHsSync),
	.oPixel(oPixel),		.oLast(oLast),
	.oDataType(oDataType),	.oVc(oVc),			.oWordCnt(oWordCnt),
	.oReq(oReq),			.iAck(iAck),		.oOverflow(oOverflow)
);

initial
begin
	iSCLK = 1'b0;
	forever #4 iSCLK = ~iSCLK;	// 8 ns period
end

// ----------------------------------------
// Table and lane driver
// ----------------------------------------
task automatic setRow(input int r, input int t, input csiDataType dt, input logic [1:0] vc,
	input logic [15:0] wc, input int dly, input bit ovf);
	tabTest[r]  = t;
	tabDt[r]    = dt;
	tabVc[r]    = vc;
	tabWc[r]    = wc;
	tabDelay[r] = dly;
	tabOvf[r]   = ovf;
endtask

task automatic loadTable();
	setRow(0, 1, dtYuv422,     2'd0, 16'd24, 0,  1'b0);	// 12 words
	setRow(1, 2, dtFrameStart, 2'd0, 16'd1,  0,  1'b0);	// Frame number in wc field
	setRow(2, 2, dtRgb565,     2'd0, 16'd18, 1,  1'b0);
	setRow(3, 3, dtRaw8,       2'd3, 16'd11, 12, 1'b0);	// Odd count rounds up
	setRow(4, 4, dtRaw8,       2'd1, 16'd10, 2,  1'b0);
	setRow(5, 4, dtYuv422,     2'd2, 16'd8,  2,  1'b0);
	setRow(6, 5, dtRgb565,     2'd0, 16'd80, 40, 1'b1);	// Overruns the FIFO
	tName[1] = "long yuv422, immediate ack";
	tName[2] = "frame start then long";
	tName[3] = "raw8, random ack delay";
	tName[4] = "back to back, vc 1 and 2";
	tName[5] = "fifo overflow";
endtask

task automatic sendWord(input logic [7:0] lane0, input logic [7:0] lane1, input logic sync);
	@(posedge iSCLK);
	iHsData0 <= lane0;
	iHsData1 <= lane1;
	iHsValid <= 1'b1;
	iHsSync  <= sync;
endtask

task automatic sendPacket(input int r, inout int expCount);
	int          nWords;
	logic [15:0] word;
	bit          isLong;
	isLong = (tabDt[r] > `CSI_LONG_DT_MIN);		// Short packets carry no payload
	nWords = isLong ? (tabWc[r] + 1) / 2 : 0;	// Two bytes per word
	sendWord(8'hB8, 8'hB8, 1'b1);				// Sync on both lanes
	sendWord({tabVc[r], tabDt[r]}, tabWc[r][7:0], 1'b0);
	sendWord(tabWc[r][15:8], 8'($urandom), 1'b0);	// Random ECC byte
	for (int i = 0; i < nWords; i++)
	begin
		word = 16'($urandom);
		sendWord(word[7:0], word[15:8], 1'b0);
		if (!tabOvf[r])
		begin
			expPix.push_back(word);
			expTag.push_back({(i == nWords - 1), tabDt[r], tabVc[r], tabWc[r]});
			expCount++;
		end
	end
endtask

// ----------------------------------------
// Sink model
// ----------------------------------------
initial
begin : sinkModel
	logic [15:0] expWord;
	logic [24:0] expFields;
	int          delay;
	int          hold;
	wait (qnHsRst === 1'b1);
	forever
	begin
		@(posedge iSCLK);
		if (oReq === 1'b1)
		begin
			sinkBusy = 1'b1;
			if (!ovfTest)
			begin
				rxCount++;
				assert (expPix.size() != 0)
				else
				begin
					$display("unexpected word at %0t: oReq with no payload outstanding", $time);
					errCount++;
				end
				if (expPix.size() != 0)
				begin
					expWord   = expPix.pop_front();
					expFields = expTag.pop_front();
					assert (oPixel === expWord)
					else
					begin
						$display("error %0t: oPixel %h, expected %h", $time, oPixel, expWord);
						errCount++;
					end
					assert ({oLast, oDataType, oVc, oWordCnt} === expFields)
					else
					begin
						$display("error %0t: last/dt/vc/wc %h, expected %h", $time,
							{oLast, oDataType, oVc, oWordCnt}, expFields);
						errCount++;
					end
				end
			end
			delay = $urandom_range(maxDelay, 0);
			hold  = $urandom_range(maxDelay, 0);
			repeat (delay) @(posedge iSCLK);
			iAck <= 1'b1;
			repeat (2) @(posedge iSCLK);	// DUT sees ack, then drops req
			assert (oReq === 1'b0)
			else
			begin
				$display("protocol violation at %0t: oReq held after iAck was seen", $time);
				errCount++;
			end
			// Ack held high a while longer, req must stay low
			repeat (hold)
			begin
				@(posedge iSCLK);
				assert (oReq === 1'b0)
				else
				begin
					$display("protocol violation at %0t: oReq rose while iAck was high", $time);
					errCount++;
				end
			end
			iAck <= 1'b0;
			sinkBusy = 1'b0;
		end
	end
end

initial
begin : watchdog
	int limit;
	wait (tableReady);
	limit = 2000;
	for (int r = 0; r < nPkt; r++)
		limit += (3 + (tabWc[r] + 1) / 2) * (tabDelay[r] + 4);	// Sync and header too
	repeat (limit) @(posedge iSCLK);
	$display("watchdog expired after %0d cycles, the run did not finish", limit);
	$display("tests failed");
	$finish;
end

// ----------------------------------------
// Main sequence
// ----------------------------------------
initial
begin : mainSeq
	int row;
	int pass;
	int expCount;
	int waitCnt;
	int errBefore;
	seed = 3347;
	void'($urandom(seed));
	qnHsRst  = 1'b0;
	iHsData0 = 8'h00;
	iHsData1 = 8'h00;
	iHsValid = 1'b0;
	iHsSync  = 1'b0;
	iAck     = 1'b0;
	loadTable();
	tableReady = 1'b1;
	repeat (16) @(posedge iSCLK);
	qnHsRst <= 1'b1;
	repeat (4) @(posedge iSCLK);
	row  = 0;
	pass = 0;
	for (int t = 1; t <= nTests; t++)
	begin
		errBefore = errCount;
		expCount  = 0;
		rxCount   = 0;
		while (row < nPkt && tabTest[row] == t)
		begin
			maxDelay = tabDelay[row];
			ovfTest  = tabOvf[row];
			sendPacket(row, expCount);
			row++;
		end
		@(posedge iSCLK);
		iHsValid <= 1'b0;	// Lanes idle
		iHsSync  <= 1'b0;
		waitCnt = 0;
		if (ovfTest)
		begin
			while (oOverflow !== 1'b1 && waitCnt < 500)
			begin
				@(posedge iSCLK);
				waitCnt++;
			end
			assert (oOverflow === 1'b1)
			else
			begin
				$display("error %0t: oOverflow low after the FIFO was overrun", $time);
				errCount++;
			end
			repeat (50) @(posedge iSCLK);
			assert (oOverflow === 1'b1)
			else
			begin
				$display("error %0t: oOverflow cleared without a reset", $time);
				errCount++;
			end
		end
		else
		begin
			while ((expPix.size() != 0 || sinkBusy) && waitCnt < 1000)
			begin
				@(posedge iSCLK);
				waitCnt++;
			end
			repeat (20) @(posedge iSCLK);	// Catch stray requests
			assert (rxCount == expCount)
			else
			begin
				$display("test %0d got %0d words where %0d were sent", t, rxCount, expCount);
				errCount++;
			end
			assert (oOverflow === 1'b0)
			else
			begin
				$display("error %0t: oOverflow set in test %0d", $time, t);
				errCount++;
			end
		end
		if (errCount == errBefore)
			pass++;
		$display("test %0d %s: %s", t, tName[t], (errCount == errBefore) ? "ok" : "failed");
	end
	$display("summary: %0d tests run, %0d ok, %0d errors", nTests, pass, errCount);
	if (errCount == 0)
		$display("all tests passed");
	else
		$display("tests failed");
	$finish;
end

endmodule
